/* include/scene_cfg.svh */
`ifndef SCENE_CFG_SVH
`define SCENE_CFG_SVH

// memory address widths
`define SCENE_VADDR_W 8
`define SCENE_TADDR_W 8

// descriptor and instance ids
`define SCENE_BUF_W  4
`define SCENE_INST_W 4

// memory and table depths
`define SCENE_NVERT (1 << `SCENE_VADDR_W)
`define SCENE_NTRI  (1 << `SCENE_TADDR_W)
`define SCENE_NBUF  (1 << `SCENE_BUF_W)
`define SCENE_NINST (1 << `SCENE_INST_W)

// payload fields
`define SCENE_COORD_W 12
`define SCENE_TRANS_W 64  // four 16-bit fields

`endif

/* verilog/scene_types_pkg.sv */
`default_nettype none
`include "scene_cfg.svh"

package scene_types_pkg;

    localparam int FIELD_W = `SCENE_TRANS_W / 4;

    // ====================================================================
    //  geometry words
    // ====================================================================
    typedef struct packed {
        logic signed [`SCENE_COORD_W-1:0] x;
        logic signed [`SCENE_COORD_W-1:0] y;
        logic signed [`SCENE_COORD_W-1:0] z;
    } vertex_t;

    // indices relative to the vertex buffer base
    typedef struct packed {
        logic [`SCENE_COORD_W-1:0] a;
        logic [`SCENE_COORD_W-1:0] b;
        logic [`SCENE_COORD_W-1:0] c;
    } tri_t;

    // one serial data word, seen as vertex or triangle by the load type
    typedef union packed {
        vertex_t vtx;
        tri_t    trg;
    } payload_u;

    // ====================================================================
    //  descriptors
    // ====================================================================
    typedef struct packed {
        logic [`SCENE_VADDR_W-1:0] base;   // same width for both memories
        logic [`SCENE_VADDR_W-1:0] count;
    } buf_desc_t;

    typedef struct packed {
        logic [`SCENE_BUF_W-1:0] vert_id;
        logic [`SCENE_BUF_W-1:0] tri_id;
    } inst_desc_t;

    typedef struct packed {
        logic signed [FIELD_W-1:0] scale;
        logic        [FIELD_W-1:0] rot;    // rotation table index
        logic signed [FIELD_W-1:0] x_off;
        logic signed [FIELD_W-1:0] y_off;
    } transform_t;

endpackage

`default_nettype wire

/* verilog/scene_cmd_pkg.sv */
`default_nettype none

package scene_cmd_pkg;

    // serial command opcodes, 5..15 are dropped
    typedef enum logic [3:0] {
        OP_WIPE   = 4'd0,
        OP_VHDR   = 4'd1,
        OP_THDR   = 4'd2,
        OP_CREATE = 4'd3,
        OP_UPDATE = 4'd4
    } scene_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_VHDR,
        ST_VDATA,
        ST_THDR,
        ST_TDATA,
        ST_CREATE,
        ST_UPDATE
    } dec_state_e;

endpackage

`default_nettype wire

/* verilog/scene_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "scene_cfg.svh"

module scene_cmd_decode (
    input  wire                              sck,
    input  wire                              rst,
    // command strobes
    input  wire                              opcode_valid,
    input  wire scene_cmd_pkg::scene_op_e    opcode,
    input  wire                              hdr_valid,
    input  wire [`SCENE_BUF_W-1:0]           buf_id,
    input  wire [`SCENE_VADDR_W-1:0]         base,
    input  wire [`SCENE_VADDR_W-1:0]         count,
    input  wire                              data_valid,
    input  wire scene_types_pkg::payload_u   payload,
    input  wire                              inst_valid,
    input  wire [`SCENE_INST_W-1:0]          inst_id,
    input  wire [`SCENE_BUF_W-1:0]           inst_vert_id,
    input  wire [`SCENE_BUF_W-1:0]           inst_tri_id,
    input  wire scene_types_pkg::transform_t transform,
    output logic                             loading,
    // memory writes
    output logic                             vert_we,
    output logic [`SCENE_VADDR_W-1:0]        vert_waddr,
    output scene_types_pkg::vertex_t         vert_wdata,
    output logic                             tri_we,
    output logic [`SCENE_TADDR_W-1:0]        tri_waddr,
    output scene_types_pkg::tri_t            tri_wdata,
    output logic                             trans_we,
    output logic [`SCENE_INST_W-1:0]         trans_waddr,
    output scene_types_pkg::transform_t      trans_wdata,
    // descriptor writes
    output logic                             vdesc_we,
    output logic                             tdesc_we,
    output logic [`SCENE_BUF_W-1:0]          desc_id,
    output scene_types_pkg::buf_desc_t       desc,
    output logic                             idesc_we,
    output logic [`SCENE_INST_W-1:0]         idesc_id,
    output scene_types_pkg::inst_desc_t      idesc,
    output logic                             wipe
);
    import scene_cmd_pkg::*;

    dec_state_e                state;
    logic [`SCENE_VADDR_W-1:0] base_q;     // start address of the load
    logic [`SCENE_VADDR_W-1:0] count_q;
    logic [`SCENE_VADDR_W-1:0] load_cnt;   // words taken so far
    logic                      op_hit;
    logic                      hdr_hit;
    logic                      data_hit;
    logic                      inst_hit;

    // unknown opcodes leave a load running
    assign op_hit   = opcode_valid && (opcode <= OP_UPDATE);
    assign hdr_hit  = !op_hit && hdr_valid && (state == ST_VHDR || state == ST_THDR);
    assign data_hit = !op_hit && data_valid && (state == ST_VDATA || state == ST_TDATA)
                      && (load_cnt < count_q);
    assign inst_hit = !op_hit && inst_valid && (state == ST_CREATE || state == ST_UPDATE);

    assign loading = (state == ST_VHDR) || (state == ST_VDATA)
                  || (state == ST_THDR) || (state == ST_TDATA);

    // ====================================================================
    //  command FSM
    // ====================================================================
    always_ff @(posedge sck) begin
        if (rst) begin
            state    <= ST_IDLE;
            count_q  <= '0;
            load_cnt <= '0;
            vert_we  <= 1'b0;
            tri_we   <= 1'b0;
            trans_we <= 1'b0;
            vdesc_we <= 1'b0;
            tdesc_we <= 1'b0;
            idesc_we <= 1'b0;
            wipe     <= 1'b0;
        end else begin
            vert_we  <= data_hit && (state == ST_VDATA);
            tri_we   <= data_hit && (state == ST_TDATA);
            trans_we <= inst_hit;                         // create and update
            vdesc_we <= hdr_hit && (state == ST_VHDR);
            tdesc_we <= hdr_hit && (state == ST_THDR);
            idesc_we <= inst_hit && (state == ST_CREATE);
            wipe     <= op_hit && (opcode == OP_WIPE);

            if (op_hit) begin
                case (opcode)
                    OP_VHDR:   state <= ST_VHDR;
                    OP_THDR:   state <= ST_THDR;
                    OP_CREATE: state <= ST_CREATE;
                    OP_UPDATE: state <= ST_UPDATE;
                    default:   state <= ST_IDLE;          // wipe
                endcase
            end else if (hdr_hit) begin
                count_q  <= count;
                load_cnt <= '0;
                state    <= (count == '0)       ? ST_IDLE  :
                            (state == ST_VHDR)  ? ST_VDATA : ST_TDATA;
            end else if (data_hit) begin
                load_cnt <= load_cnt + 1'b1;
                if (load_cnt + 1'b1 == count_q)
                    state <= ST_IDLE;                     // last word leaves now
            end else if (inst_hit) begin
                state <= ST_IDLE;
            end
        end
    end

    // write payloads, valid alongside their enables
    always_ff @(posedge sck) begin
        if (hdr_hit) begin
            base_q  <= base;
            desc_id <= buf_id;
            desc    <= '{base: base, count: count};
        end
        if (data_hit) begin
            if (state == ST_VDATA) begin
                vert_waddr <= base_q + load_cnt;
                vert_wdata <= payload.vtx;
            end else begin
                tri_waddr <= base_q + load_cnt;
                tri_wdata <= payload.trg;
            end
        end
        if (inst_hit) begin
            trans_waddr <= inst_id;
            trans_wdata <= transform;
            idesc_id    <= inst_id;
            idesc       <= '{vert_id: inst_vert_id, tri_id: inst_tri_id};
        end
    end

    // a data state always has a word left to take
    a_cnt_bound: assert property (@(posedge sck) disable iff (rst)
        (state == ST_VDATA || state == ST_TDATA) |-> load_cnt < count_q);

    // a cycle spent idle is followed by no write
    a_idle_quiet: assert property (@(posedge sck) disable iff (rst)
        (state == ST_IDLE) |=>
            !(vert_we || tri_we || trans_we || vdesc_we || tdesc_we || idesc_we));

endmodule

`default_nettype wire

/* verilog/scene_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "scene_cfg.svh"

module scene_store (
    input  wire                              sck,
    // writes from decode
    input  wire                              vert_we,
    input  wire [`SCENE_VADDR_W-1:0]         vert_waddr,
    input  wire scene_types_pkg::vertex_t    vert_wdata,
    input  wire                              tri_we,
    input  wire [`SCENE_TADDR_W-1:0]         tri_waddr,
    input  wire scene_types_pkg::tri_t       tri_wdata,
    input  wire                              trans_we,
    input  wire [`SCENE_INST_W-1:0]          trans_waddr,
    input  wire scene_types_pkg::transform_t trans_wdata,
    // frame driver reads
    input  wire [`SCENE_VADDR_W-1:0]         vert_addr_rd,
    input  wire [`SCENE_TADDR_W-1:0]         tri_addr_rd,
    input  wire [`SCENE_INST_W-1:0]          inst_id_rd,
    output scene_types_pkg::vertex_t         vert_out,
    output scene_types_pkg::tri_t            tri_out,
    output scene_types_pkg::transform_t      transform_out
);
    import scene_types_pkg::*;

    vertex_t    vert_mem  [`SCENE_NVERT];
    tri_t       tri_mem   [`SCENE_NTRI];
    transform_t trans_mem [`SCENE_NINST];   // one per instance

    // ====================================================================
    //  memories, one write port and one registered read each
    // ====================================================================
    always_ff @(posedge sck) begin
        if (vert_we) begin
            vert_mem[vert_waddr] <= vert_wdata;
        end
        vert_out <= vert_mem[vert_addr_rd];  // old word on a same-cycle hit
    end

    always_ff @(posedge sck) begin
        if (tri_we) begin
            tri_mem[tri_waddr] <= tri_wdata;
        end
        tri_out <= tri_mem[tri_addr_rd];
    end

    always_ff @(posedge sck) begin
        if (trans_we) begin
            trans_mem[trans_waddr] <= trans_wdata;
        end
        transform_out <= trans_mem[inst_id_rd];
    end

    // decode only ever drives one kind of load at a time
    a_one_writer: assert property (@(posedge sck)
        !$isunknown({vert_we, tri_we, trans_we}) |->
            $onehot0({vert_we, tri_we, trans_we}));

endmodule

`default_nettype wire

/* verilog/scene_desc_table.sv */
`timescale 1ns/1ps
`default_nettype none
`include "scene_cfg.svh"

module scene_desc_table (
    input  wire                              sck,
    input  wire                              rst,
    input  wire                              wipe,
    // buffer descriptor writes
    input  wire                              vdesc_we,
    input  wire                              tdesc_we,
    input  wire [`SCENE_BUF_W-1:0]           desc_id,
    input  wire scene_types_pkg::buf_desc_t  desc,
    // instance descriptor writes
    input  wire                              idesc_we,
    input  wire [`SCENE_INST_W-1:0]          idesc_id,
    input  wire scene_types_pkg::inst_desc_t idesc,
    // lookup
    input  wire [`SCENE_INST_W-1:0]          inst_id_rd,
    output scene_types_pkg::buf_desc_t       vert_desc_out,
    output scene_types_pkg::buf_desc_t       tri_desc_out
);
    import scene_types_pkg::*;

    buf_desc_t  vert_tab [`SCENE_NBUF];
    buf_desc_t  tri_tab  [`SCENE_NBUF];
    inst_desc_t inst_tab [`SCENE_NINST];
    inst_desc_t inst_sel;                   // entry of the requested instance

    // ====================================================================
    //  tables, cleared by reset and by wipe
    // ====================================================================
    always_ff @(posedge sck) begin
        if (rst || wipe) begin
            for (int i = 0; i < `SCENE_NBUF; i++) begin
                vert_tab[i] <= '0;
                tri_tab[i]  <= '0;
            end
            for (int i = 0; i < `SCENE_NINST; i++) begin
                inst_tab[i] <= '0;
            end
        end else begin
            if (vdesc_we)
                vert_tab[desc_id] <= desc;
            if (tdesc_we)
                tri_tab[desc_id] <= desc;
            if (idesc_we)
                inst_tab[idesc_id] <= idesc;
        end
    end

    // instance to buffer ids to descriptors, one register stage
    assign inst_sel = inst_tab[inst_id_rd];

    always_ff @(posedge sck) begin
        vert_desc_out <= vert_tab[inst_sel.vert_id];
        tri_desc_out  <= tri_tab[inst_sel.tri_id];
    end

    // decode never pairs a wipe with a descriptor write
    a_wipe_alone: assert property (@(posedge sck) disable iff (rst)
        wipe |-> !(vdesc_we || tdesc_we || idesc_we));

endmodule

`default_nettype wire

/* verilog/scene_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "scene_cfg.svh"

module scene_mem_top (
    input  wire                              sck,
    input  wire                              rst,
    // command strobes
    input  wire                              opcode_valid,
    input  wire scene_cmd_pkg::scene_op_e    opcode,
    input  wire                              hdr_valid,
    input  wire [`SCENE_BUF_W-1:0]           buf_id,
    input  wire [`SCENE_VADDR_W-1:0]         base,
    input  wire [`SCENE_VADDR_W-1:0]         count,
    input  wire                              data_valid,
    input  wire scene_types_pkg::payload_u   payload,
    input  wire                              inst_valid,
    input  wire [`SCENE_INST_W-1:0]          inst_id,
    input  wire [`SCENE_BUF_W-1:0]           inst_vert_id,
    input  wire [`SCENE_BUF_W-1:0]           inst_tri_id,
    input  wire scene_types_pkg::transform_t transform,
    // frame driver side
    input  wire [`SCENE_INST_W-1:0]          inst_id_rd,
    input  wire [`SCENE_VADDR_W-1:0]         vert_addr_rd,
    input  wire [`SCENE_TADDR_W-1:0]         tri_addr_rd,
    output logic                             loading,
    output scene_types_pkg::vertex_t         vert_out,
    output scene_types_pkg::tri_t            tri_out,
    output scene_types_pkg::transform_t      transform_out,
    output scene_types_pkg::buf_desc_t       vert_desc_out,
    output scene_types_pkg::buf_desc_t       tri_desc_out
);
    import scene_types_pkg::*;

    // ====================================================================
    //  decode to store
    // ====================================================================
    logic                      vert_we;
    logic [`SCENE_VADDR_W-1:0] vert_waddr;
    vertex_t                   vert_wdata;
    logic                      tri_we;
    logic [`SCENE_TADDR_W-1:0] tri_waddr;
    tri_t                      tri_wdata;
    logic                      trans_we;
    logic [`SCENE_INST_W-1:0]  trans_waddr;
    transform_t                trans_wdata;

    // decode to descriptor table
    logic                      vdesc_we;
    logic                      tdesc_we;
    logic [`SCENE_BUF_W-1:0]   desc_id;
    buf_desc_t                 desc;
    logic                      idesc_we;
    logic [`SCENE_INST_W-1:0]  idesc_id;
    inst_desc_t                idesc;
    logic                      wipe;

    scene_cmd_decode decode_i (.*);
    scene_store      store_i  (.*);
    scene_desc_table desc_i   (.*);

endmodule

`default_nettype wire

/* dv/scene_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "scene_cfg.svh"

module scene_mem_tb;
    import scene_types_pkg::*;
    import scene_cmd_pkg::*;

    localparam int CLK_NS  = 4;
    localparam int MAX_CNT = 24;                  // longest random load
    localparam int STROBES = 64 + 4 * MAX_CNT;
    localparam int READS   = 9 * (MAX_CNT + 3) + 4 * (`SCENE_NINST + 3);
    localparam int LIMIT_NS = 2 * (5 + STROBES + READS) * CLK_NS;

    logic sck, rst;
    logic opcode_valid, hdr_valid, data_valid, inst_valid;
    scene_op_e opcode;
    logic [`SCENE_BUF_W-1:0]   buf_id, inst_vert_id, inst_tri_id;
    logic [`SCENE_VADDR_W-1:0] base, count, vert_addr_rd;
    logic [`SCENE_TADDR_W-1:0] tri_addr_rd;
    logic [`SCENE_INST_W-1:0]  inst_id, inst_id_rd;
    payload_u   payload;
    transform_t transform, transform_out;
    logic       loading;
    vertex_t    vert_out;
    tri_t       tri_out;
    buf_desc_t  vert_desc_out, tri_desc_out;

    scene_mem_top dut_i (.*);

    always #2 sck = ~sck;

    // ====================================================================
    //  reference model
    // ====================================================================
    vertex_t    vert_model  [`SCENE_NVERT];
    tri_t       tri_model   [`SCENE_NTRI];
    transform_t trans_model [`SCENE_NINST];
    logic       trans_known [`SCENE_NINST];   // transform written at least once
    buf_desc_t  vdesc_model [`SCENE_NBUF];
    buf_desc_t  tdesc_model [`SCENE_NBUF];
    inst_desc_t idesc_model [`SCENE_NINST];
    dec_state_e m_state;
    logic [`SCENE_VADDR_W-1:0] m_base, m_count, m_loaded;

    // expected read values, one cycle behind the addresses like the DUT
    logic       vchk_en, tchk_en, ichk_en, load_nxt;
    logic       vchk_q, tchk_q, ichk_q, xchk_q, load_exp;
    vertex_t    exp_vert;
    tri_t       exp_tri;
    transform_t exp_trans;
    buf_desc_t  exp_vdesc, exp_tdesc;

    always @(posedge sck) begin
        vchk_q    <= vchk_en;
        tchk_q    <= tchk_en;
        ichk_q    <= ichk_en;
        xchk_q    <= ichk_en && trans_known[inst_id_rd];
        exp_vert  <= vert_model[vert_addr_rd];
        exp_tri   <= tri_model[tri_addr_rd];
        exp_trans <= trans_model[inst_id_rd];
        exp_vdesc <= vdesc_model[idesc_model[inst_id_rd].vert_id];
        exp_tdesc <= tdesc_model[idesc_model[inst_id_rd].tri_id];
        load_exp  <= load_nxt;
    end

    task automatic mismatch(input string sig, input logic [63:0] exp, input logic [63:0] act);
        $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, sig, exp, act);
        $display("TB FAILED");
        $fatal(1, "%s differs from the model", sig);
    endtask

    a_vert: assert property (@(posedge sck) vchk_q |-> vert_out == exp_vert)
        else mismatch("vert_out", 64'($sampled(exp_vert)), 64'($sampled(vert_out)));
    a_tri: assert property (@(posedge sck) tchk_q |-> tri_out == exp_tri)
        else mismatch("tri_out", 64'($sampled(exp_tri)), 64'($sampled(tri_out)));
    a_trans: assert property (@(posedge sck) xchk_q |-> transform_out == exp_trans)
        else mismatch("transform_out", 64'($sampled(exp_trans)), 64'($sampled(transform_out)));
    a_vdesc: assert property (@(posedge sck) ichk_q |-> vert_desc_out == exp_vdesc)
        else mismatch("vert_desc_out", 64'($sampled(exp_vdesc)), 64'($sampled(vert_desc_out)));
    a_tdesc: assert property (@(posedge sck) ichk_q |-> tri_desc_out == exp_tdesc)
        else mismatch("tri_desc_out", 64'($sampled(exp_tdesc)), 64'($sampled(tri_desc_out)));
    a_loading: assert property (@(posedge sck) disable iff (rst) loading == load_exp)
        else mismatch("loading", 64'($sampled(load_exp)), 64'($sampled(loading)));

    // ====================================================================
    //  strobes, each called at a falling edge and lasting one cycle
    // ====================================================================
    task automatic send_op(input scene_op_e op);
        opcode_valid = 1'b1;
        opcode       = op;
        if (op == OP_WIPE) begin
            vdesc_model = '{default: '0};
            tdesc_model = '{default: '0};
            idesc_model = '{default: '0};
        end
        m_state  = (op == OP_VHDR)   ? ST_VHDR   :
                   (op == OP_THDR)   ? ST_THDR   :
                   (op == OP_CREATE) ? ST_CREATE :
                   (op == OP_UPDATE) ? ST_UPDATE : ST_IDLE;
        load_nxt = (op == OP_VHDR) || (op == OP_THDR);  // aborts any load
        @(negedge sck);
        opcode_valid = 1'b0;
    endtask

    task automatic send_hdr(input logic [`SCENE_BUF_W-1:0] id,
                            input logic [`SCENE_VADDR_W-1:0] b,
                            input logic [`SCENE_VADDR_W-1:0] c);
        hdr_valid = 1'b1;
        buf_id    = id;
        base      = b;
        count     = c;
        if (m_state == ST_VHDR || m_state == ST_THDR) begin
            if (m_state == ST_VHDR)
                vdesc_model[id] = '{base: b, count: c};
            else
                tdesc_model[id] = '{base: b, count: c};
            m_base   = b;
            m_count  = c;
            m_loaded = '0;
            if (c == '0) begin
                m_state  = ST_IDLE;
                load_nxt = 1'b0;
            end else begin
                m_state = (m_state == ST_VHDR) ? ST_VDATA : ST_TDATA;
            end
        end
        @(negedge sck);
        hdr_valid = 1'b0;
    endtask

    task automatic send_data;
        logic [63:0] r;
        r          = {$urandom, $urandom};
        data_valid = 1'b1;
        payload    = r[35:0];
        if ((m_state == ST_VDATA || m_state == ST_TDATA) && m_loaded < m_count) begin
            if (m_state == ST_VDATA)
                vert_model[m_base + m_loaded] = payload.vtx;
            else
                tri_model[m_base + m_loaded] = payload.trg;
            m_loaded = m_loaded + 1'b1;
            if (m_loaded == m_count) begin
                m_state  = ST_IDLE;
                load_nxt = 1'b0;
            end
        end
        @(negedge sck);
        data_valid = 1'b0;
    endtask

    task automatic send_inst(input logic [`SCENE_INST_W-1:0] id,
                             input logic [`SCENE_BUF_W-1:0] vid,
                             input logic [`SCENE_BUF_W-1:0] tid);
        inst_valid   = 1'b1;
        inst_id      = id;
        inst_vert_id = vid;
        inst_tri_id  = tid;
        transform    = {$urandom, $urandom};
        if (m_state == ST_CREATE)
            idesc_model[id] = '{vert_id: vid, tri_id: tid};
        if (m_state == ST_CREATE || m_state == ST_UPDATE) begin
            trans_model[id] = transform;     // update touches only this
            trans_known[id] = 1'b1;
            m_state         = ST_IDLE;
        end
        @(negedge sck);
        inst_valid = 1'b0;
    endtask

    // ====================================================================
    //  read sweeps
    // ====================================================================
    task automatic sweep_vert(input logic [7:0] b, input logic [7:0] n);
        logic [`SCENE_VADDR_W-1:0] a;
        repeat (2) @(negedge sck);           // let the last write land
        a       = b;
        vchk_en = 1'b1;
        repeat (n) begin
            vert_addr_rd = a;
            a            = a + 1'b1;
            @(negedge sck);
        end
        vchk_en = 1'b0;
        @(negedge sck);
    endtask

    task automatic sweep_tri(input logic [7:0] b, input logic [7:0] n);
        logic [`SCENE_TADDR_W-1:0] a;
        repeat (2) @(negedge sck);
        a       = b;
        tchk_en = 1'b1;
        repeat (n) begin
            tri_addr_rd = a;
            a           = a + 1'b1;
            @(negedge sck);
        end
        tchk_en = 1'b0;
        @(negedge sck);
    endtask

    task automatic sweep_inst;
        logic [`SCENE_INST_W-1:0] id;
        repeat (2) @(negedge sck);
        id      = '0;
        ichk_en = 1'b1;
        repeat (`SCENE_NINST) begin
            inst_id_rd = id;
            id         = id + 1'b1;
            @(negedge sck);
        end
        ichk_en = 1'b0;
        @(negedge sck);
    endtask

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired after %0d ns, the run hung", LIMIT_NS);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    logic [7:0] v_base, v_cnt, t_base, t_cnt, v2_base, t2_base;

    initial begin
        void'($urandom(32'h7eae));
        sck = 1'b0;
        rst = 1'b1;
        {opcode_valid, hdr_valid, data_valid, inst_valid} = '0;
        opcode = OP_WIPE;
        {buf_id, base, count, payload} = '0;
        {inst_id, inst_vert_id, inst_tri_id, transform} = '0;
        {inst_id_rd, vert_addr_rd, tri_addr_rd} = '0;
        {vchk_en, tchk_en, ichk_en, load_nxt} = '0;
        vdesc_model = '{default: '0};
        tdesc_model = '{default: '0};
        idesc_model = '{default: '0};
        trans_known = '{default: 1'b0};
        m_state     = ST_IDLE;
        {m_base, m_count, m_loaded} = '0;
        repeat (5) @(negedge sck);
        rst = 1'b0;

        // vertex load then readback
        v_base = 8'($urandom);
        v_cnt  = 8'(4 + $urandom_range(MAX_CNT - 4));
        send_op(OP_VHDR);
        send_hdr(4'd3, v_base, v_cnt);
        repeat (v_cnt) send_data();
        sweep_vert(v_base, v_cnt);

        // triangle load, vertex words must survive
        t_base = 8'($urandom);
        t_cnt  = 8'(4 + $urandom_range(MAX_CNT - 4));
        send_op(OP_THDR);
        send_hdr(4'd5, t_base, t_cnt);
        repeat (t_cnt) send_data();
        sweep_tri(t_base, t_cnt);
        sweep_vert(v_base, v_cnt);

        // second pair of buffers for the other instance
        v2_base = 8'($urandom);
        t2_base = 8'($urandom);
        send_op(OP_VHDR);
        send_hdr(4'd9, v2_base, 8'd4);
        repeat (4) send_data();
        send_op(OP_THDR);
        send_hdr(4'd12, t2_base, 8'd4);
        repeat (4) send_data();

        // create two instances, then update one
        send_op(OP_CREATE);
        send_inst(4'd2, 4'd3, 4'd5);
        send_op(OP_CREATE);
        send_inst(4'd11, 4'd9, 4'd12);
        sweep_inst();
        send_op(OP_UPDATE);
        send_inst(4'd2, 4'd9, 4'd12);        // ids here must not stick
        sweep_inst();

        // short reload with extra words, then data in idle
        send_op(OP_VHDR);
        send_hdr(4'd3, v_base, v_cnt >> 1);
        repeat ((v_cnt >> 1) + 8'd3) send_data();
        repeat (3) send_data();
        sweep_vert(v_base, v_cnt);

        // abort a triangle reload halfway
        send_op(OP_THDR);
        send_hdr(4'd5, t_base, t_cnt);
        repeat (t_cnt >> 1) send_data();
        send_op(OP_THDR);
        repeat (3) send_data();
        send_hdr(4'd14, t2_base, 8'd0);
        sweep_tri(t_base, t_cnt);
        sweep_inst();

        // wipe aborts a short load and clears descriptors only
        send_op(OP_VHDR);
        send_hdr(4'd7, v2_base, 8'd4);
        send_data();
        send_op(OP_WIPE);
        repeat (2) send_data();              // idle with words still owed
        sweep_inst();
        sweep_vert(v_base, v_cnt);
        sweep_tri(t_base, t_cnt);
        sweep_vert(v2_base, 8'd4);
        sweep_tri(t2_base, 8'd4);

        repeat (2) @(negedge sck);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
verilog/scene_types_pkg.sv
verilog/scene_cmd_pkg.sv
verilog/scene_cmd_decode.sv
verilog/scene_store.sv
verilog/scene_desc_table.sv
verilog/scene_mem_top.sv
dv/scene_mem_tb.sv

/* Makefile */
# Verilator build and run of the scene memory testbench

VERILATOR ?= verilator
TOP       ?= scene_mem_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TB PASSED$$" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
